/* list.f */
src/crc_pkg.sv
src/host_interface.sv
src/crc_data_buffer.sv
src/crc_datapath.sv
src/crc_ahb_top.sv
verif/crc_tb.sv

/* Bender.yml */
package:
  name: crc_ahb

sources:
  - src/crc_pkg.sv
  - src/host_interface.sv
  - src/crc_data_buffer.sv
  - src/crc_datapath.sv
  - src/crc_ahb_top.sv
  - target: test
    files:
      - verif/crc_tb.sv

/* verif/crc_tb.sv */
/*
 Self-checking testbench of the AHB-Lite CRC unit, single master on the bus
 Transfers are not pipelined, except the back-to-back data register bursts
 Register reads are checked by a concurrent assertion against a software CRC model
 Random data comes from $urandom with a fixed seed
*/
`timescale 1ns/1ps

module crc_tb;

	localparam int HALF_PERIOD = 50;
	// Whole run needs under 3000 cycles, the limit leaves a wide margin
	localparam int unsigned MAX_CYCLES = 20000;

	logic           HCLK;
	logic           HRESETn;
	logic           HSElx;
	logic [31:0]    HADDR;
	logic [1:0]     HTRANS;
	logic           HWRITE;
	logic [2:0]     HSIZE;
	crc_pkg::word_t HWDATA;
	logic           HREADY;
	crc_pkg::word_t HRDATA;
	logic           HREADYOUT;
	logic           HRESP;

	// Reference model state
	crc_pkg::word_t      model_crc;
	crc_pkg::word_t      model_init;
	crc_pkg::word_t      model_poly;
	crc_pkg::poly_size_t model_width;
	crc_pkg::rev_in_t    model_rev_in;
	logic                model_rev_out;

	// Expected read word, read data phase tracker, wait state flag
	crc_pkg::word_t exp_rdata;
	logic           rd_dphase;
	logic           saw_stall;
	int unsigned    cycles;

	crc_ahb_top #(.BUFFER_DEPTH(4)) UUT
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	// Only slave on the bus
	assign HREADY = HREADYOUT;

	always #HALF_PERIOD HCLK = !HCLK;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	//////////////////////////////////////////////////
	// Checkers and run limit
	//////////////////////////////////////////////////

	// Marks a read data phase, advances only when the slave is ready
	always @(posedge HCLK)
	begin
		if (!HRESETn)
			rd_dphase <= 1'b0;
		else if (HREADYOUT)
			rd_dphase <= HSElx && (HTRANS == crc_pkg::HTRANS_NONSEQ) && !HWRITE;
	end

	always @(posedge HCLK)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
			abort_run("Timeout, the run did not finish within the cycle limit");
	end

	read_data_ok: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(rd_dphase && HREADYOUT) |-> (HRDATA == exp_rdata))
	else
		abort_run($sformatf("Fail at %0t: HRDATA expected %08h actual %08h",
			$time, $sampled(exp_rdata), $sampled(HRDATA)));

	hresp_okay: assert property (@(posedge HCLK) HRESP == 1'b0)
	else
		abort_run($sformatf("Fail at %0t: HRESP expected 0 actual %b", $time, $sampled(HRESP)));

	//////////////////////////////////////////////////
	// Reference CRC model
	//////////////////////////////////////////////////

	function automatic int unsigned width_bits(input crc_pkg::poly_size_t ps);
		case (ps)
			2'd1:    return 16;
			2'd2:    return 8;
			2'd3:    return 7;
			default: return 32;
		endcase
	endfunction

	function automatic crc_pkg::word_t low_mask(input int unsigned n);
		return (n == 32) ? 32'hFFFF_FFFF : ((32'd1 << n) - 1);
	endfunction

	// Reversal unit in bits, a unit of 1 leaves the data as it is
	function automatic int unsigned unit_bits(input crc_pkg::rev_in_t rev);
		case (rev)
			2'd1:    return 8;
			2'd2:    return 16;
			2'd3:    return 32;
			default: return 1;
		endcase
	endfunction

	// Folds one transfer of nbytes low bytes into the CRC, MSB first
	function automatic crc_pkg::word_t fold_transfer(input crc_pkg::word_t crc,
	                                                 input crc_pkg::word_t data,
	                                                 input int unsigned nbytes,
	                                                 input int unsigned unit,
	                                                 input crc_pkg::word_t poly,
	                                                 input int unsigned n);
		crc_pkg::word_t mask;
		crc_pkg::word_t seq;
		int unsigned    bits;
		int unsigned    u;
		logic           fb;
		mask = low_mask(n);
		bits = nbytes * 8;
		// Unit larger than the transfer reverses the whole transfer
		u    = (unit > bits) ? bits : unit;
		seq  = '0;
		for (int i = 0; i < int'(bits); i++)
			seq[(i / u) * u + (u - 1 - i % u)] = data[i];
		for (int i = int'(bits) - 1; i >= 0; i--)
		begin
			fb  = crc[n-1] ^ seq[i];
			crc = (crc << 1) & mask;
			if (fb)
				crc = crc ^ (poly & mask);
		end
		return crc;
	endfunction

	// Data register value, optionally reversed across the N valid bits
	function automatic crc_pkg::word_t result_value(input crc_pkg::word_t crc,
	                                                input int unsigned n,
	                                                input logic rev);
		crc_pkg::word_t r;
		r = '0;
		for (int i = 0; i < int'(n); i++)
			r[i] = rev ? crc[n-1-i] : crc[i];
		return r;
	endfunction

	task automatic model_feed(input crc_pkg::bus_size_t size, input crc_pkg::word_t data);
		model_crc = fold_transfer(model_crc, data, 1 << size, unit_bits(model_rev_in),
		                          model_poly, width_bits(model_width));
	endtask

	//////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////

	task automatic drive_addr(input crc_pkg::reg_addr_t idx, input logic write,
	                          input crc_pkg::bus_size_t size, input logic sel,
	                          input logic [1:0] trans);
		HSElx  = sel;
		HADDR  = {27'h0, idx, 2'b00};
		HTRANS = trans;
		HWRITE = write;
		HSIZE  = {1'b0, size};
	endtask

	task automatic drive_idle;
		HSElx  = 1'b0;
		HTRANS = 2'b00;
		HWRITE = 1'b0;
	endtask

	// Ends the data phase on the edge where HREADYOUT is high
	task automatic wait_ready;
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			saw_stall = 1'b1;
			@(negedge HCLK);
		end
		@(posedge HCLK);
		#1;
	endtask

	task automatic write_raw(input crc_pkg::reg_addr_t idx, input crc_pkg::bus_size_t size,
	                         input crc_pkg::word_t data, input logic sel,
	                         input logic [1:0] trans);
		drive_addr(idx, 1'b1, size, sel, trans);
		@(posedge HCLK);
		#1;
		HWDATA = data;
		drive_idle();
		wait_ready();
	endtask

	// Records the expected word, the assertion compares it in the data phase
	task automatic read_check(input crc_pkg::reg_addr_t idx, input crc_pkg::word_t expected);
		exp_rdata = expected;
		drive_addr(idx, 1'b0, crc_pkg::SIZE_WORD, 1'b1, crc_pkg::HTRANS_NONSEQ);
		@(posedge HCLK);
		#1;
		drive_idle();
		wait_ready();
	endtask

	task automatic check_crc;
		read_check(crc_pkg::REG_DR,
		           result_value(model_crc, width_bits(model_width), model_rev_out));
	endtask

	task automatic data_write(input crc_pkg::bus_size_t size, input crc_pkg::word_t data);
		write_raw(crc_pkg::REG_DR, size, data, 1'b1, crc_pkg::HTRANS_NONSEQ);
		model_feed(size, data);
	endtask

	// Word write to any register, model follows
	task automatic reg_write(input crc_pkg::reg_addr_t idx, input crc_pkg::word_t data);
		write_raw(idx, crc_pkg::SIZE_WORD, data, 1'b1, crc_pkg::HTRANS_NONSEQ);
		case (idx)
			crc_pkg::REG_DR:   model_feed(crc_pkg::SIZE_WORD, data);
			crc_pkg::REG_INIT: model_init = data;
			crc_pkg::REG_POL:  model_poly = data;
			crc_pkg::REG_CR:
			begin
				model_width   = data[crc_pkg::CR_POLY_SIZE_LSB +: 2];
				model_rev_in  = data[crc_pkg::CR_REV_IN_LSB +: 2];
				model_rev_out = data[crc_pkg::CR_REV_OUT_BIT];
				if (data[crc_pkg::CR_RESET_BIT])
					model_crc = model_init & low_mask(width_bits(model_width));
			end
			default:;
		endcase
	endtask

	// Back-to-back DR words, next address phase overlaps the current data phase
	task automatic burst_write(input int unsigned count);
		crc_pkg::word_t data;
		drive_addr(crc_pkg::REG_DR, 1'b1, crc_pkg::SIZE_WORD, 1'b1, crc_pkg::HTRANS_NONSEQ);
		@(posedge HCLK);
		#1;
		for (int unsigned i = 0; i < count; i++)
		begin
			data   = $urandom;
			HWDATA = data;
			if (i + 1 == count)
				drive_idle();
			model_feed(crc_pkg::SIZE_WORD, data);
			wait_ready();
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		crc_pkg::word_t cr_val;
		crc_pkg::word_t new_init;
		void'($urandom(63));
		HCLK          = 1'b0;
		HRESETn       = 1'b0;
		HSElx         = 1'b0;
		HADDR         = '0;
		HTRANS        = 2'b00;
		HWRITE        = 1'b0;
		HSIZE         = 3'd0;
		HWDATA        = '0;
		cycles        = 0;
		saw_stall     = 1'b0;
		exp_rdata     = '0;
		model_crc     = 32'hFFFF_FFFF;
		model_init    = crc_pkg::RESET_INIT;
		model_poly    = crc_pkg::RESET_POLY;
		model_width   = crc_pkg::POLY_32;
		model_rev_in  = crc_pkg::REV_NONE;
		model_rev_out = 1'b0;
		repeat (4) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		// Reset values
		check_crc();
		read_check(crc_pkg::REG_IDR, 32'h0);
		read_check(crc_pkg::REG_CR, 32'h0);
		read_check(crc_pkg::REG_INIT, crc_pkg::RESET_INIT);
		read_check(crc_pkg::REG_POL, crc_pkg::RESET_POLY);

		// Readback, IDR keeps 8 bits, CR bit 0 reads as zero
		reg_write(crc_pkg::REG_IDR, 32'h1234_56A5);
		read_check(crc_pkg::REG_IDR, 32'h0000_00A5);
		reg_write(crc_pkg::REG_INIT, 32'h8BAD_F00D);
		read_check(crc_pkg::REG_INIT, 32'h8BAD_F00D);
		reg_write(crc_pkg::REG_POL, 32'h1EDC_6F41);
		read_check(crc_pkg::REG_POL, 32'h1EDC_6F41);
		reg_write(crc_pkg::REG_CR, 32'h0000_00F9);
		read_check(crc_pkg::REG_CR, 32'h0000_00F8);
		// IDLE and unselected writes are ignored
		write_raw(crc_pkg::REG_IDR, crc_pkg::SIZE_WORD, 32'h0000_003C, 1'b1, 2'b00);
		write_raw(crc_pkg::REG_IDR, crc_pkg::SIZE_WORD, 32'h0000_003C, 1'b0,
		          crc_pkg::HTRANS_NONSEQ);
		write_raw(crc_pkg::REG_POL, crc_pkg::SIZE_WORD, 32'h0, 1'b0, crc_pkg::HTRANS_NONSEQ);
		read_check(crc_pkg::REG_IDR, 32'h0000_00A5);
		read_check(crc_pkg::REG_POL, 32'h1EDC_6F41);

		// Default CRC-32 over 20 random words
		reg_write(crc_pkg::REG_POL, crc_pkg::RESET_POLY);
		reg_write(crc_pkg::REG_INIT, crc_pkg::RESET_INIT);
		reg_write(crc_pkg::REG_CR, 32'h0000_0001);
		repeat (20)
			reg_write(crc_pkg::REG_DR, $urandom);
		check_crc();

		// All widths, input and output reversal modes, mixed sizes
		for (int w = 0; w < 4; w++)
			for (int ro = 0; ro < 2; ro++)
				for (int ri = 0; ri < 4; ri++)
				begin
					cr_val = (ro << 7) | (ri << 5) | (w << 3) | 1;
					reg_write(crc_pkg::REG_POL, $urandom);
					reg_write(crc_pkg::REG_INIT, $urandom);
					reg_write(crc_pkg::REG_CR, cr_val);
					for (int k = 0; k < 6; k++)
						data_write(crc_pkg::bus_size_t'(k % 3), $urandom);
					check_crc();
				end

		// Bursts overfill the 4-entry buffer
		reg_write(crc_pkg::REG_CR, 32'h0000_0061);
		saw_stall = 1'b0;
		burst_write(10);
		burst_write(10);
		assert (saw_stall)
		else
			abort_run("Back-pressure bursts never saw HREADYOUT low");
		check_crc();

		// Init write during a pending chain reset waits for the drain
		burst_write(6);
		reg_write(crc_pkg::REG_CR, 32'h0000_0061);
		new_init  = $urandom;
		saw_stall = 1'b0;
		reg_write(crc_pkg::REG_INIT, new_init);
		assert (saw_stall)
		else
			abort_run("Init write during a pending chain reset was not stalled");
		repeat (3)
			reg_write(crc_pkg::REG_DR, $urandom);
		check_crc();
		read_check(crc_pkg::REG_INIT, new_init);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* src/crc_ahb_top.sv */
/*
 AHB-Lite CRC unit, host interface, word buffer and CRC engine
 No DMA or interrupt, HRESP is always OKAY
 Data reads have no fixed latency and complete on HREADYOUT
*/
`timescale 1ns/1ps

module crc_ahb_top
#(
	parameter int BUFFER_DEPTH = 4
)
(
	input  logic           HCLK,
	input  logic           HRESETn,
	input  logic           HSElx,
	input  logic [31:0]    HADDR,
	input  logic [1:0]     HTRANS,
	input  logic           HWRITE,
	input  logic [2:0]     HSIZE,
	input  crc_pkg::word_t HWDATA,
	input  logic           HREADY,
	output crc_pkg::word_t HRDATA,
	output logic           HREADYOUT,
	output logic           HRESP
);

	// Bus side to buffer and engine
	crc_pkg::word_t      bus_wr;
	crc_pkg::bus_size_t  bus_size;
	logic                buffer_write_en;
	logic                crc_init_en;
	logic                crc_poly_en;
	logic                crc_idr_en;
	logic                reset_chain;
	crc_pkg::poly_size_t crc_poly_size;
	crc_pkg::rev_in_t    rev_in_type;
	logic                rev_out_type;

	// Buffer head and status
	crc_pkg::word_t      rd_data;
	crc_pkg::bus_size_t  rd_size;
	logic                buffer_full;
	logic                buffer_empty;
	logic                buffer_read;

	// Engine results back to the bus side
	crc_pkg::word_t      crc_out;
	crc_pkg::word_t      crc_init_out;
	crc_pkg::word_t      crc_poly_out;
	crc_pkg::idr_t       crc_idr_out;
	logic                read_wait;
	logic                reset_pending;

	host_interface u_host_interface
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSIZE           (HSIZE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.read_wait       (read_wait),
		.reset_pending   (reset_pending),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.crc_idr_en      (crc_idr_en),
		.reset_chain     (reset_chain),
		.crc_poly_size   (crc_poly_size),
		.rev_in_type     (rev_in_type),
		.rev_out_type    (rev_out_type)
	);

	crc_data_buffer #(
		.BUFFER_DEPTH (BUFFER_DEPTH)
	) u_crc_data_buffer
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.buffer_write_en (buffer_write_en),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_read     (buffer_read),
		.rd_data         (rd_data),
		.rd_size         (rd_size),
		.buffer_full     (buffer_full),
		.buffer_empty    (buffer_empty)
	);

	crc_datapath u_crc_datapath
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.reset_chain   (reset_chain),
		.crc_poly_size (crc_poly_size),
		.rev_in_type   (rev_in_type),
		.rev_out_type  (rev_out_type),
		.buffer_empty  (buffer_empty),
		.rd_data       (rd_data),
		.rd_size       (rd_size),
		.buffer_read   (buffer_read),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.read_wait     (read_wait),
		.reset_pending (reset_pending)
	);

endmodule

/* src/crc_datapath.sv */
/*
 CRC engine, one byte per clock, polynomial widths 32, 16, 8 or 7
 Control fields must not change while words are queued or shifting
 A chain reset is applied only after the queue has drained
*/
`timescale 1ns/1ps

module crc_datapath
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  crc_pkg::word_t      bus_wr,
	input  logic                crc_init_en,
	input  logic                crc_poly_en,
	input  logic                crc_idr_en,
	input  logic                reset_chain,
	input  crc_pkg::poly_size_t crc_poly_size,
	input  crc_pkg::rev_in_t    rev_in_type,
	input  logic                rev_out_type,
	input  logic                buffer_empty,
	input  crc_pkg::word_t      rd_data,
	input  crc_pkg::bus_size_t  rd_size,
	output logic                buffer_read,
	output crc_pkg::word_t      crc_out,
	output crc_pkg::word_t      crc_init_out,
	output crc_pkg::word_t      crc_poly_out,
	output crc_pkg::idr_t       crc_idr_out,
	output logic                read_wait,
	output logic                reset_pending
);

	crc_pkg::dp_state_e state;
	logic [1:0]         byte_cnt;
	logic [1:0]         first_cnt;
	crc_pkg::word_t     data_sr;
	crc_pkg::word_t     crc_q;
	crc_pkg::word_t     init_q;
	crc_pkg::word_t     poly_q;
	crc_pkg::idr_t      idr_q;

	crc_pkg::word_t     width_mask;
	logic [4:0]         out_shift;
	crc_pkg::word_t     in_full_rev;
	crc_pkg::rev_in_t   eff_rev;
	crc_pkg::word_t     in_rev;
	crc_pkg::word_t     in_aligned;
	crc_pkg::word_t     crc_rev;
	logic               shifting;
	logic               apply_reset;

	// Full 32-bit bit reversal
	function automatic crc_pkg::word_t reverse_word(input crc_pkg::word_t w);
		crc_pkg::word_t r;
		for (int i = 0; i < 32; i++)
			r[i] = w[31-i];
		return r;
	endfunction

	// Eight serial CRC steps, MSB of the byte first
	function automatic crc_pkg::word_t crc_byte(input crc_pkg::word_t crc,
	                                            input logic [7:0] d,
	                                            input crc_pkg::word_t poly,
	                                            input crc_pkg::word_t mask);
		crc_pkg::word_t c;
		crc_pkg::word_t top;
		logic           fb;
		c   = crc;
		// Single bit at position N-1
		top = mask ^ (mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = (|(c & top)) ^ d[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////
	// Width and input alignment
	//////////////////////////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			crc_pkg::POLY_16: width_mask = 32'h0000_FFFF;
			crc_pkg::POLY_8:  width_mask = 32'h0000_00FF;
			crc_pkg::POLY_7:  width_mask = 32'h0000_007F;
			default:          width_mask = 32'hFFFF_FFFF;
		endcase
		// Moves a full reversal back down to the low N bits
		case (crc_poly_size)
			crc_pkg::POLY_16: out_shift = 5'd16;
			crc_pkg::POLY_8:  out_shift = 5'd24;
			crc_pkg::POLY_7:  out_shift = 5'd25;
			default:          out_shift = 5'd0;
		endcase
	end

	// Reversal unit is clipped to the transfer size
	always_comb
	begin
		in_full_rev = reverse_word(rd_data);
		eff_rev     = rev_in_type;
		if ((rd_size == crc_pkg::SIZE_BYTE) && (rev_in_type != crc_pkg::REV_NONE))
			eff_rev = crc_pkg::REV_BYTE;
		else if ((rd_size == crc_pkg::SIZE_HALF) && (rev_in_type == crc_pkg::REV_WORD))
			eff_rev = crc_pkg::REV_HALF;

		// Byte and halfword reversal from the full reversal by lane swaps
		case (eff_rev)
			crc_pkg::REV_BYTE: in_rev = {in_full_rev[7:0], in_full_rev[15:8],
			                             in_full_rev[23:16], in_full_rev[31:24]};
			crc_pkg::REV_HALF: in_rev = {in_full_rev[15:0], in_full_rev[31:16]};
			crc_pkg::REV_WORD: in_rev = in_full_rev;
			default:           in_rev = rd_data;
		endcase

		// First byte to feed goes to the top of the shift register
		case (rd_size)
			crc_pkg::SIZE_BYTE:
			begin
				in_aligned = {in_rev[7:0], 24'h0};
				first_cnt  = 2'd0;
			end
			crc_pkg::SIZE_HALF:
			begin
				in_aligned = {in_rev[15:0], 16'h0};
				first_cnt  = 2'd1;
			end
			default:
			begin
				in_aligned = in_rev;
				first_cnt  = 2'd3;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Engine FSM
	//////////////////////////////////////////////////

	assign shifting    = (state == crc_pkg::DP_SHIFT);
	assign buffer_read = (state == crc_pkg::DP_IDLE) && !buffer_empty;
	assign apply_reset = reset_pending && (state == crc_pkg::DP_IDLE) && buffer_empty;

	// A read also waits out a pending chain reset so it sees the restarted value
	assign read_wait = !buffer_empty || shifting || reset_pending;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state         <= crc_pkg::DP_IDLE;
			byte_cnt      <= 2'd0;
			reset_pending <= 1'b0;
		end
		else
		begin
			case (state)
				crc_pkg::DP_IDLE:
					if (buffer_read)
					begin
						state    <= crc_pkg::DP_SHIFT;
						byte_cnt <= first_cnt;
					end
				default:
				begin
					byte_cnt <= byte_cnt - 1'b1;
					if (byte_cnt == 2'd0)
						state <= crc_pkg::DP_IDLE;
				end
			endcase
			// New request wins over the clear
			if (reset_chain)
				reset_pending <= 1'b1;
			else if (apply_reset)
				reset_pending <= 1'b0;
		end
	end

	// Byte shift register, loaded on the pop edge
	always_ff @(posedge HCLK)
	begin
		if (buffer_read)
			data_sr <= in_aligned;
		else if (shifting)
			data_sr <= data_sr << 8;
	end

	//////////////////////////////////////////////////
	// Configuration and CRC registers
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_q  <= '1;
			init_q <= crc_pkg::RESET_INIT;
			poly_q <= crc_pkg::RESET_POLY;
			idr_q  <= '0;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
			// Restart only happens in idle, never during a shift
			if (shifting)
				crc_q <= crc_byte(crc_q, data_sr[31:24], poly_q, width_mask);
			else if (apply_reset)
				crc_q <= init_q & width_mask;
		end
	end

	// Output reversal spans only the N valid bits
	assign crc_rev = reverse_word(crc_q) >> out_shift;
	assign crc_out = (rev_out_type ? crc_rev : crc_q) & width_mask;

	assign crc_init_out = init_q;
	assign crc_poly_out = poly_q;
	assign crc_idr_out  = idr_q;

endmodule

/* src/crc_data_buffer.sv */
/*
 Circular FIFO of data words and their transfer sizes
 Pushes while full and pops while empty are ignored
 A pushed entry appears at the head on the next cycle
*/
`timescale 1ns/1ps

module crc_data_buffer
#(
	parameter int BUFFER_DEPTH = 4
)
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               buffer_write_en,
	input  crc_pkg::word_t     bus_wr,
	input  crc_pkg::bus_size_t bus_size,
	input  logic               buffer_read,
	output crc_pkg::word_t     rd_data,
	output crc_pkg::bus_size_t rd_size,
	output logic               buffer_full,
	output logic               buffer_empty
);

	localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

	// Entry storage
	crc_pkg::word_t     data_mem [BUFFER_DEPTH];
	crc_pkg::bus_size_t size_mem [BUFFER_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Wrap also covers depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUFFER_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign buffer_empty = (count == '0);
	assign buffer_full  = (count == CNT_W'(BUFFER_DEPTH));

	assign do_push = buffer_write_en && !buffer_full;
	assign do_pop  = buffer_read && !buffer_empty;

	// Head of queue
	assign rd_data = data_mem[rd_ptr];
	assign rd_size = size_mem[rd_ptr];

	always_ff @(posedge HCLK)
	begin
		if (do_push)
		begin
			data_mem[wr_ptr] <= bus_wr;
			size_mem[wr_ptr] <= bus_size;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the count unchanged
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/host_interface.sv */
/*
 AHB-Lite slave front end of the CRC unit
 HRESP is always OKAY, only NONSEQ transfers are decoded
 Data register accesses use the low byte lanes regardless of HADDR[1:0]
 Wait states are inserted only for full buffer, busy engine or pending chain reset
*/
`timescale 1ns/1ps

module host_interface
(
	input  logic                  HCLK,
	input  logic                  HRESETn,
	input  logic                  HSElx,
	input  logic [31:0]           HADDR,
	input  logic [1:0]            HTRANS,
	input  logic                  HWRITE,
	input  logic [2:0]            HSIZE,
	input  crc_pkg::word_t        HWDATA,
	input  logic                  HREADY,
	input  crc_pkg::word_t        crc_out,
	input  crc_pkg::word_t        crc_init_out,
	input  crc_pkg::word_t        crc_poly_out,
	input  crc_pkg::idr_t         crc_idr_out,
	input  logic                  buffer_full,
	input  logic                  read_wait,
	input  logic                  reset_pending,
	output crc_pkg::word_t        HRDATA,
	output logic                  HREADYOUT,
	output logic                  HRESP,
	output crc_pkg::word_t        bus_wr,
	output crc_pkg::bus_size_t    bus_size,
	output logic                  buffer_write_en,
	output logic                  crc_init_en,
	output logic                  crc_poly_en,
	output logic                  crc_idr_en,
	output logic                  reset_chain,
	output crc_pkg::poly_size_t   crc_poly_size,
	output crc_pkg::rev_in_t      rev_in_type,
	output logic                  rev_out_type
);

	// Address phase pipeline
	crc_pkg::reg_addr_t haddr_pp;
	crc_pkg::bus_size_t hsize_pp;
	logic [1:0]         htrans_pp;
	logic               hwrite_pp;
	logic               hselx_pp;

	// Stored control fields, bits 7 down to 3
	logic [crc_pkg::CR_REV_OUT_BIT:crc_pkg::CR_POLY_SIZE_LSB] cr_q;

	logic sample_bus;
	logic access_en;
	logic write_en;
	logic read_en;
	logic dr_wr_req;
	logic dr_rd_req;
	logic init_wr_req;
	logic cr_en;

	//////////////////////////////////////////////////
	// Address phase sampling
	//////////////////////////////////////////////////

	// A new address phase is taken only when the previous data phase ends
	assign sample_bus = HREADY && HREADYOUT;

	// Transfer qualifiers, cleared so that no access is seen after reset
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= 2'b00;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Register index and size, only meaningful with a live access
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	//////////////////////////////////////////////////
	// Decode and wait states
	//////////////////////////////////////////////////

	assign access_en = hselx_pp && (htrans_pp == crc_pkg::HTRANS_NONSEQ);
	assign write_en  = access_en && hwrite_pp;
	assign read_en   = access_en && !hwrite_pp;

	// Requests that may have to wait
	assign dr_wr_req   = write_en && (haddr_pp == crc_pkg::REG_DR);
	assign dr_rd_req   = read_en && (haddr_pp == crc_pkg::REG_DR);
	assign init_wr_req = write_en && (haddr_pp == crc_pkg::REG_INIT);

	// Data phase is held while any of the three conditions is true
	assign HREADYOUT = !((dr_wr_req && buffer_full) ||
	                     (dr_rd_req && read_wait) ||
	                     (init_wr_req && reset_pending));

	// No error responses
	assign HRESP = 1'b0;

	// Write strobes fire at the end of an unstalled data phase
	assign buffer_write_en = dr_wr_req && HREADYOUT;
	assign crc_init_en     = init_wr_req && HREADYOUT;
	assign crc_poly_en     = write_en && (haddr_pp == crc_pkg::REG_POL);
	assign crc_idr_en      = write_en && (haddr_pp == crc_pkg::REG_IDR);
	assign cr_en           = write_en && (haddr_pp == crc_pkg::REG_CR);

	// Write data is taken straight from the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	//////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_q <= '0;
		else if (cr_en)
			cr_q <= HWDATA[crc_pkg::CR_REV_OUT_BIT:crc_pkg::CR_POLY_SIZE_LSB];
	end

	// Chain reset bit acts as a strobe and is not stored
	assign reset_chain   = cr_en && HWDATA[crc_pkg::CR_RESET_BIT];
	assign crc_poly_size = cr_q[crc_pkg::CR_POLY_SIZE_LSB +: 2];
	assign rev_in_type   = cr_q[crc_pkg::CR_REV_IN_LSB +: 2];
	assign rev_out_type  = cr_q[crc_pkg::CR_REV_OUT_BIT];

	// Read mux, unmapped indexes read as zero
	always_comb
	begin
		case (haddr_pp)
			crc_pkg::REG_DR:   HRDATA = crc_out;
			crc_pkg::REG_IDR:  HRDATA = {24'h0, crc_idr_out};
			crc_pkg::REG_CR:   HRDATA = {24'h0, cr_q, 3'b000};
			crc_pkg::REG_INIT: HRDATA = crc_init_out;
			crc_pkg::REG_POL:  HRDATA = crc_poly_out;
			default:           HRDATA = '0;
		endcase
	end

endmodule

/* src/crc_pkg.sv */
/*
 Shared definitions of the AHB-Lite CRC unit
 Register indexes come from HADDR[4:2], so registers sit on a 4-byte pitch
 Control register fields below bit 3 are write-only or reserved
*/
package crc_pkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	// Bus word and CRC word
	typedef logic [31:0] word_t;
	// Free-use identification value
	typedef logic [7:0] idr_t;
	// Low bits of HSIZE
	typedef logic [1:0] bus_size_t;
	// Polynomial width code
	typedef logic [1:0] poly_size_t;
	// Input bit reversal code
	typedef logic [1:0] rev_in_t;
	// Register index from HADDR[4:2]
	typedef logic [2:0] reg_addr_t;

	// Engine FSM states
	typedef enum logic [0:0]
	{
		DP_IDLE,
		DP_SHIFT
	} dp_state_e;

	//////////////////////////////////////////////////
	// Register map and encodings
	//////////////////////////////////////////////////

	localparam reg_addr_t REG_DR   = 3'd0;
	localparam reg_addr_t REG_IDR  = 3'd1;
	localparam reg_addr_t REG_CR   = 3'd2;
	localparam reg_addr_t REG_INIT = 3'd4;
	localparam reg_addr_t REG_POL  = 3'd5;

	// Only NONSEQ starts an access here
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Reset values of the init and polynomial registers
	localparam word_t RESET_INIT = 32'hFFFF_FFFF;
	localparam word_t RESET_POLY = 32'h04C1_1DB7;

	// Transfer sizes
	localparam bus_size_t SIZE_BYTE = 2'd0;
	localparam bus_size_t SIZE_HALF = 2'd1;
	localparam bus_size_t SIZE_WORD = 2'd2;

	// Polynomial widths
	localparam poly_size_t POLY_32 = 2'd0;
	localparam poly_size_t POLY_16 = 2'd1;
	localparam poly_size_t POLY_8  = 2'd2;
	localparam poly_size_t POLY_7  = 2'd3;

	// Input reversal units
	localparam rev_in_t REV_NONE = 2'd0;
	localparam rev_in_t REV_BYTE = 2'd1;
	localparam rev_in_t REV_HALF = 2'd2;
	localparam rev_in_t REV_WORD = 2'd3;

	// Control register layout
	localparam int unsigned CR_RESET_BIT     = 0;
	localparam int unsigned CR_POLY_SIZE_LSB = 3;
	localparam int unsigned CR_REV_IN_LSB    = 5;
	localparam int unsigned CR_REV_OUT_BIT   = 7;

endpackage
